// ==== common/uncore_defs.svh ====
`ifndef UNCORE_DEFS_SVH
`define UNCORE_DEFS_SVH

// bus and line widths
`define UNC_ADDR_W      32
`define UNC_DATA_W      32
`define UNC_LINE_W      128

// refill burst shape with one line per burst
`define UNC_BEATS       4
`define UNC_ARLEN       8'd3
`define UNC_ARSIZE      3'd2
`define UNC_ARBURST     2'd1

// axi ids per requester
`define UNC_ID_I        4'd0
`define UNC_ID_D        4'd1

// commit trace buffering
`define UNC_TRACE_DEPTH 16

`endif

// ==== common/axi_rd_pkg.sv ====
`include "uncore_defs.svh"

package axi_rd_pkg;

    // read address channel
    typedef struct packed {
        logic [3:0]             id;
        logic [`UNC_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
        logic                   valid;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [3:0]             id;
        logic [`UNC_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
        logic                   valid;
    } axi_r_t;

    // cache request held until rvalid
    typedef struct packed {
        logic                   ren;
        logic [`UNC_ADDR_W-1:0] addr;
    } refill_req_t;

    typedef struct packed {
        logic                   rvalid;
        logic [`UNC_LINE_W-1:0] line;
    } refill_rsp_t;

endpackage

// ==== common/trace_pkg.sv ====
`include "uncore_defs.svh"

package trace_pkg;

    // one retired instruction as seen by the debug port
    typedef struct packed {
        logic                   valid;
        logic                   rf_we;
        logic [4:0]             rf_wnum;
        logic [`UNC_DATA_W-1:0] rf_wdata;
        logic [`UNC_DATA_W-1:0] inst;
        logic [`UNC_ADDR_W-1:0] pc;
    } retire_rec_t;

endpackage

// ==== refill/refill_arbiter.sv ====
`timescale 1ns/1ps
`include "uncore_defs.svh"

module refill_arbiter
    import axi_rd_pkg::*;
(
    input  logic                   aclk,
    input  logic                   arst_n_i,
    input  refill_req_t            icache_req_i,
    input  refill_req_t            dcache_req_i,
    output refill_rsp_t            icache_rsp_o,
    output refill_rsp_t            dcache_rsp_o,
    output logic                   refill_rdy_o,
    output logic                   start_o,
    output logic [`UNC_ADDR_W-1:0] start_addr_o,
    output logic [3:0]             start_id_o,
    input  logic                   done_i,
    input  logic [`UNC_LINE_W-1:0] line_i
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } arb_state_e;

    arb_state_e             state_q;
    logic                   gnt_d_q;
    logic                   start_q;
    logic                   any_req;
    logic [`UNC_ADDR_W-1:0] addr_q;
    logic [3:0]             id_q;

    assign any_req = icache_req_i.ren | dcache_req_i.ren;

    // ******************************
    // grant fsm
    // ******************************
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            gnt_d_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    // dcache has priority
                    if (any_req) begin
                        state_q <= ST_BUSY;
                        gnt_d_q <= dcache_req_i.ren;
                        start_q <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (done_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // burst address and id for the winner
    always_ff @(posedge aclk) begin
        if (state_q == ST_IDLE && any_req) begin
            if (dcache_req_i.ren) begin
                addr_q <= dcache_req_i.addr;
                id_q   <= `UNC_ID_D;
            end else begin
                addr_q <= icache_req_i.addr;
                id_q   <= `UNC_ID_I;
            end
        end
    end

    assign start_o      = start_q;
    assign start_addr_o = addr_q;
    assign start_id_o   = id_q;
    assign refill_rdy_o = (state_q == ST_IDLE);

    // line goes back to whoever holds the grant
    always_comb begin
        icache_rsp_o.rvalid = done_i & ~gnt_d_q;
        icache_rsp_o.line   = line_i;
        dcache_rsp_o.rvalid = done_i & gnt_d_q;
        dcache_rsp_o.line   = line_i;
    end

    // reader only finishes a burst this arbiter started
    done_busy_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        done_i |-> state_q == ST_BUSY);

endmodule

// ==== refill/axi_burst_reader.sv ====
`timescale 1ns/1ps
`include "uncore_defs.svh"

module axi_burst_reader
    import axi_rd_pkg::*;
(
    input  logic                   aclk,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  logic [`UNC_ADDR_W-1:0] addr_i,
    input  logic [3:0]             id_i,
    output axi_ar_t                ar_o,
    output logic                   rready_o,
    output logic                   done_o,
    output logic [`UNC_LINE_W-1:0] line_o,
    input  logic                   arready_i,
    input  axi_r_t                 r_i
);

    localparam int BEAT_W = $clog2(`UNC_BEATS);

    // done is also the resting state between bursts
    typedef enum logic [1:0] {
        ST_ADDR,
        ST_DATA,
        ST_DONE
    } rd_state_e;

    rd_state_e              state_q;
    logic [BEAT_W-1:0]      beat_q;
    logic                   done_q;
    logic                   beat_ok;
    logic [`UNC_ADDR_W-1:0] addr_q;
    logic [3:0]             id_q;
    logic [`UNC_LINE_W-1:0] line_q;

    assign rready_o = (state_q == ST_DATA);
    assign beat_ok  = rready_o & r_i.valid;

    // ******************************
    // burst fsm
    // ******************************
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_DONE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_DONE: begin
                    if (start_i) begin
                        state_q <= ST_ADDR;
                        beat_q  <= '0;
                    end
                end
                ST_ADDR: begin
                    if (arready_i) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (beat_ok) begin
                        beat_q <= beat_q + 1'b1;
                        if (r_i.last) begin
                            state_q <= ST_DONE;
                            done_q  <= 1'b1;
                        end
                    end
                end
                default: state_q <= ST_DONE;
            endcase
        end
    end

    // beat k lands in word k of the line
    always_ff @(posedge aclk) begin
        if (state_q == ST_DONE && start_i) begin
            addr_q <= addr_i;
            id_q   <= id_i;
        end
        if (beat_ok) begin
            line_q[beat_q*`UNC_DATA_W +: `UNC_DATA_W] <= r_i.data;
        end
    end

    always_comb begin
        ar_o.id    = id_q;
        ar_o.addr  = addr_q;
        ar_o.len   = `UNC_ARLEN;
        ar_o.size  = `UNC_ARSIZE;
        ar_o.burst = `UNC_ARBURST;
        ar_o.valid = (state_q == ST_ADDR);
    end

    assign done_o = done_q;
    assign line_o = line_q;

    ar_hold_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        ar_o.valid && !arready_i |=> $stable(ar_o));

    r_id_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        beat_ok |-> r_i.id == id_q);

    // slave must end the burst exactly on the fourth beat
    r_last_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        beat_ok |-> r_i.last == (beat_q == BEAT_W'(`UNC_BEATS - 1)));

endmodule

// ==== logic/commit_trace_fifo.sv ====
`timescale 1ns/1ps
`include "uncore_defs.svh"

module commit_trace_fifo
    import trace_pkg::*;
(
    input  logic        aclk,
    input  logic        arst_n_i,
    input  retire_rec_t retire1_i,
    input  retire_rec_t retire2_i,
    output retire_rec_t rec_o
);

    localparam int PTR_W = $clog2(`UNC_TRACE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    retire_rec_t      mem_q [`UNC_TRACE_DEPTH];
    retire_rec_t      out_q;
    logic             out_vld_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr2;
    logic [CNT_W-1:0] count_q;
    logic [1:0]       n_push;
    logic             pop;

    assign n_push = {1'b0, retire1_i.valid} + {1'b0, retire2_i.valid};
    assign pop    = (count_q != '0);
    // slot 2 goes right after slot 1, or first if slot 1 is empty
    assign wr_ptr2 = wr_ptr_q + PTR_W'(retire1_i.valid);

    // ******************************
    // pointers and fill level
    // ******************************
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            out_vld_q <= 1'b0;
        end else begin
            wr_ptr_q  <= wr_ptr_q + PTR_W'(n_push);
            rd_ptr_q  <= rd_ptr_q + PTR_W'(pop);
            count_q   <= count_q + CNT_W'(n_push) - CNT_W'(pop);
            out_vld_q <= pop;
        end
    end

    // storage and output record
    always_ff @(posedge aclk) begin
        if (retire1_i.valid) begin
            mem_q[wr_ptr_q] <= retire1_i;
        end
        if (retire2_i.valid) begin
            mem_q[wr_ptr2] <= retire2_i;
        end
        if (pop) begin
            out_q <= mem_q[rd_ptr_q];
        end
    end

    always_comb begin
        rec_o       = out_q;
        rec_o.valid = out_vld_q;
    end

    // retire side must never push more than there is room for
    no_overrun_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        int'(count_q) + int'(n_push) <= `UNC_TRACE_DEPTH + int'(pop));

endmodule

// ==== logic/uncore_top.sv ====
`timescale 1ns/1ps
`include "uncore_defs.svh"

module uncore_top
    import axi_rd_pkg::*;
    import trace_pkg::*;
(
    input  logic                   aclk,
    input  logic                   arst_n_i,
    // cache refill side
    input  refill_req_t            icache_req_i,
    input  refill_req_t            dcache_req_i,
    output refill_rsp_t            icache_rsp_o,
    output refill_rsp_t            dcache_rsp_o,
    output logic                   refill_rdy_o,
    // axi read
    output axi_ar_t                ar_o,
    input  logic                   arready_i,
    input  axi_r_t                 r_i,
    output logic                   rready_o,
    // retire side
    input  retire_rec_t            retire1_i,
    input  retire_rec_t            retire2_i,
    // debug writeback
    output logic [`UNC_ADDR_W-1:0] debug_wb_pc_o,
    output logic [3:0]             debug_wb_rf_we_o,
    output logic [4:0]             debug_wb_rf_wnum_o,
    output logic [`UNC_DATA_W-1:0] debug_wb_rf_wdata_o,
    output logic [`UNC_DATA_W-1:0] debug_wb_inst_o,
    output logic                   debug_wb_valid_o
);

    logic                   start;
    logic [`UNC_ADDR_W-1:0] start_addr;
    logic [3:0]             start_id;
    logic                   done;
    logic [`UNC_LINE_W-1:0] line;
    retire_rec_t            rec;

    // ******************************
    // refill path
    // ******************************
    refill_arbiter u_arbiter (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .icache_req_i (icache_req_i),
        .dcache_req_i (dcache_req_i),
        .icache_rsp_o (icache_rsp_o),
        .dcache_rsp_o (dcache_rsp_o),
        .refill_rdy_o (refill_rdy_o),
        .start_o      (start),
        .start_addr_o (start_addr),
        .start_id_o   (start_id),
        .done_i       (done),
        .line_i       (line)
    );

    axi_burst_reader u_reader (
        .aclk      (aclk),
        .arst_n_i  (arst_n_i),
        .start_i   (start),
        .addr_i    (start_addr),
        .id_i      (start_id),
        .ar_o      (ar_o),
        .rready_o  (rready_o),
        .done_o    (done),
        .line_o    (line),
        .arready_i (arready_i),
        .r_i       (r_i)
    );

    // ******************************
    // trace path
    // ******************************
    commit_trace_fifo u_trace (
        .aclk      (aclk),
        .arst_n_i  (arst_n_i),
        .retire1_i (retire1_i),
        .retire2_i (retire2_i),
        .rec_o     (rec)
    );

    // write enable is per byte lane on the debug port
    assign debug_wb_rf_we_o    = {4{rec.rf_we & rec.valid}};
    assign debug_wb_valid_o    = rec.valid;
    assign debug_wb_pc_o       = rec.pc;
    assign debug_wb_rf_wnum_o  = rec.rf_wnum;
    assign debug_wb_rf_wdata_o = rec.rf_wdata;
    assign debug_wb_inst_o     = rec.inst;

endmodule

// ==== testbench/tb_uncore.sv ====
`timescale 1ns/1ps
`include "uncore_defs.svh"

module tb_uncore
    import axi_rd_pkg::*;
    import trace_pkg::*;
();

    localparam int N_ENTRIES   = 6;
    localparam int MAX_GAP     = 4;
    localparam int CYCLE_LIMIT = N_ENTRIES * (2 * (7 + `UNC_BEATS * MAX_GAP)) + 64;

    typedef struct {
        string       name;
        logic        req_i;
        logic        req_d;
        logic [31:0] addr_i;
        logic [31:0] addr_d;
        logic        stall;
        retire_rec_t ret1;
        retire_rec_t ret2;
    } entry_t;

    logic        aclk;
    logic        arst_n_i;
    refill_req_t icache_req_i;
    refill_req_t dcache_req_i;
    refill_rsp_t icache_rsp_o;
    refill_rsp_t dcache_rsp_o;
    logic        refill_rdy_o;
    axi_ar_t     ar_o;
    logic        arready_i;
    axi_r_t      r_i;
    logic        rready_o;
    retire_rec_t retire1_i;
    retire_rec_t retire2_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_we_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;
    logic [31:0] debug_wb_inst_o;
    logic        debug_wb_valid_o;

    entry_t      tbl [N_ENTRIES];
    string       cur_name;
    logic        stall_en;
    logic        pend_i;
    logic        pend_d;
    int          cycles;
    axi_ar_t     exp_ar_q [$];
    retire_rec_t exp_trace_q [$];

    uncore_top dut (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // ******************************
    // checking helpers
    // ******************************
    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // memory contents follow the address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [127:0] line_for(input logic [31:0] addr);
        logic [127:0] line;
        for (int k = 0; k < `UNC_BEATS; k++) begin
            line[32*k +: 32] = mem_word(addr + 32'(4 * k));
        end
        return line;
    endfunction

    // incr burst of four 32 bit words
    function automatic axi_ar_t make_ar(input logic [31:0] addr, input logic [3:0] id);
        axi_ar_t ar;
        ar.id    = id;
        ar.addr  = addr;
        ar.len   = 8'd3;
        ar.size  = 3'd2;
        ar.burst = 2'd1;
        ar.valid = 1'b1;
        return ar;
    endfunction

    function automatic retire_rec_t make_rec(input logic vld, input logic we,
                                             input logic [4:0] wnum, input logic [31:0] pc);
        retire_rec_t r;
        r.valid    = vld;
        r.rf_we    = we;
        r.rf_wnum  = wnum;
        r.rf_wdata = pc ^ 32'h3C3C_0000;
        r.inst     = {pc[15:0], 16'h0513};
        r.pc       = pc;
        return r;
    endfunction

    function automatic int draw_gap();
        return stall_en ? int'($urandom % MAX_GAP) : 0;
    endfunction

    task automatic load_table();
        tbl[0] = '{"icache_single", 1'b1, 1'b0, 32'h0000_1000, 32'h0, 1'b0,
                   make_rec(1'b1, 1'b1, 5'd1, 32'h0000_1000), make_rec(1'b0, 1'b0, 5'd0, 32'h0)};
        tbl[1] = '{"both_requests", 1'b1, 1'b1, 32'h0000_2040, 32'h8000_0100, 1'b0,
                   make_rec(1'b1, 1'b1, 5'd2, 32'h0000_2000),
                   make_rec(1'b1, 1'b0, 5'd7, 32'h0000_2004)};
        tbl[2] = '{"icache_stall", 1'b1, 1'b0, 32'h0000_3010, 32'h0, 1'b1,
                   make_rec(1'b0, 1'b0, 5'd0, 32'h0), make_rec(1'b1, 1'b1, 5'd9, 32'h0000_3010)};
        tbl[3] = '{"both_stall", 1'b1, 1'b1, 32'h0000_4020, 32'h9000_0200, 1'b1,
                   make_rec(1'b1, 1'b1, 5'd12, 32'h0000_4020),
                   make_rec(1'b1, 1'b1, 5'd31, 32'h0000_4024)};
        tbl[4] = '{"trace_only", 1'b0, 1'b0, 32'h0, 32'h0, 1'b0,
                   make_rec(1'b1, 1'b0, 5'd4, 32'h0000_5000),
                   make_rec(1'b1, 1'b1, 5'd5, 32'h0000_5004)};
        tbl[5] = '{"both_stall_high", 1'b1, 1'b1, 32'h0000_fff0, 32'hA000_0FF0, 1'b1,
                   make_rec(1'b0, 1'b0, 5'd0, 32'h0), make_rec(1'b0, 1'b0, 5'd0, 32'h0)};
    endtask

    // ******************************
    // stimulus
    // ******************************
    task automatic apply_entry(input entry_t e);
        @(negedge aclk);
        cur_name = e.name;
        stall_en = e.stall;
        // dcache wins when both ask together
        if (e.req_d) begin
            pend_d       = 1'b1;
            dcache_req_i = '{ren: 1'b1, addr: e.addr_d};
            exp_ar_q.push_back(make_ar(e.addr_d, `UNC_ID_D));
        end
        if (e.req_i) begin
            pend_i       = 1'b1;
            icache_req_i = '{ren: 1'b1, addr: e.addr_i};
            exp_ar_q.push_back(make_ar(e.addr_i, `UNC_ID_I));
        end
        retire1_i = e.ret1;
        retire2_i = e.ret2;
        if (e.ret1.valid) begin
            exp_trace_q.push_back(e.ret1);
        end
        if (e.ret2.valid) begin
            exp_trace_q.push_back(e.ret2);
        end
        @(negedge aclk);
        retire1_i = '0;
        retire2_i = '0;
        while (pend_i || pend_d) @(negedge aclk);
    endtask

    // axi slave side serving one burst at a time
    task automatic serve_burst();
        axi_ar_t ar;
        axi_ar_t exp;
        int      gap;
        int      k;
        gap = draw_gap();
        repeat (gap) @(negedge aclk);
        ar = ar_o;
        if (exp_ar_q.size() == 0) begin
            $display("ERROR: AR issued while no refill was pending");
            stop_with_failure();
        end
        exp = exp_ar_q.pop_front();
        check_value({cur_name, " ar"}, exp, ar);
        arready_i = 1'b1;
        @(negedge aclk);
        arready_i = 1'b0;
        for (k = 0; k < `UNC_BEATS; k++) begin
            gap = draw_gap();
            repeat (gap) @(negedge aclk);
            check_value({cur_name, " rready"}, 1'b1, rready_o);
            r_i.id    = ar.id;
            r_i.data  = mem_word(ar.addr + 32'(4 * k));
            r_i.resp  = 2'b00;
            r_i.last  = (k == `UNC_BEATS - 1);
            r_i.valid = 1'b1;
            @(negedge aclk);
            r_i = '0;
        end
    endtask

    // ******************************
    // monitors
    // ******************************
    task automatic check_refill_rsp();
        if (icache_rsp_o.rvalid) begin
            if (!pend_i) begin
                $display("ERROR: icache rvalid pulsed with no request pending");
                stop_with_failure();
            end
            check_value({cur_name, " icache line"}, line_for(icache_req_i.addr),
                        icache_rsp_o.line);
            check_value({cur_name, " dcache served first"}, 1'b0, pend_d);
            check_value({cur_name, " rdy while busy"}, 1'b0, refill_rdy_o);
            pend_i       = 1'b0;
            icache_req_i = '0;
        end
        if (dcache_rsp_o.rvalid) begin
            if (!pend_d) begin
                $display("ERROR: dcache rvalid pulsed with no request pending");
                stop_with_failure();
            end
            check_value({cur_name, " dcache line"}, line_for(dcache_req_i.addr),
                        dcache_rsp_o.line);
            check_value({cur_name, " rdy while busy"}, 1'b0, refill_rdy_o);
            pend_d       = 1'b0;
            dcache_req_i = '0;
        end
    endtask

    task automatic check_trace();
        retire_rec_t exp;
        if (debug_wb_valid_o) begin
            if (exp_trace_q.size() == 0) begin
                $display("ERROR: debug port showed a record that was never retired");
                stop_with_failure();
            end
            exp = exp_trace_q.pop_front();
            check_value({cur_name, " wb pc"}, exp.pc, debug_wb_pc_o);
            check_value({cur_name, " wb inst"}, exp.inst, debug_wb_inst_o);
            check_value({cur_name, " wb wnum"}, exp.rf_wnum, debug_wb_rf_wnum_o);
            check_value({cur_name, " wb wdata"}, exp.rf_wdata, debug_wb_rf_wdata_o);
            check_value({cur_name, " wb we"}, {4{exp.rf_we}}, debug_wb_rf_we_o);
        end else begin
            check_value({cur_name, " idle wb we"}, 4'b0000, debug_wb_rf_we_o);
        end
    endtask

    initial begin
        @(posedge arst_n_i);
        forever begin
            @(negedge aclk);
            if (ar_o.valid) begin
                serve_burst();
            end
        end
    end

    initial begin
        @(posedge arst_n_i);
        forever begin
            @(negedge aclk);
            check_refill_rsp();
            check_trace();
        end
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    // ******************************
    // main sequence
    // ******************************
    initial begin
        void'($urandom(32'h35a1d12e));
        arst_n_i     = 1'b0;
        icache_req_i = '0;
        dcache_req_i = '0;
        arready_i    = 1'b0;
        r_i          = '0;
        retire1_i    = '0;
        retire2_i    = '0;
        stall_en     = 1'b0;
        pend_i       = 1'b0;
        pend_d       = 1'b0;
        cycles       = 0;
        cur_name     = "reset_state";
        load_table();
        repeat (5) @(negedge aclk);
        arst_n_i = 1'b1;
        @(negedge aclk);
        check_value("reset_state ar valid", 1'b0, ar_o.valid);
        check_value("reset_state rready", 1'b0, rready_o);
        check_value("reset_state icache rvalid", 1'b0, icache_rsp_o.rvalid);
        check_value("reset_state dcache rvalid", 1'b0, dcache_rsp_o.rvalid);
        check_value("reset_state wb valid", 1'b0, debug_wb_valid_o);
        check_value("reset_state wb we", 4'b0000, debug_wb_rf_we_o);
        check_value("reset_state refill rdy", 1'b1, refill_rdy_o);
        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_entry(tbl[i]);
        end
        // let the trace fifo run dry
        while (exp_trace_q.size() != 0) @(negedge aclk);
        @(negedge aclk);
        cur_name = "trace_empty";
        check_value("trace_empty wb valid", 1'b0, debug_wb_valid_o);
        check_value("trace_empty wb we", 4'b0000, debug_wb_rf_we_o);
        check_value("trace_empty refill rdy", 1'b1, refill_rdy_o);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+common
common/axi_rd_pkg.sv
common/trace_pkg.sv
refill/refill_arbiter.sv
refill/axi_burst_reader.sv
logic/commit_trace_fifo.sv
logic/uncore_top.sv
testbench/tb_uncore.sv

// ==== Bender.yml ====
package:
  name: uncore

export_include_dirs:
  - common

sources:
  - common/axi_rd_pkg.sv
  - common/trace_pkg.sv
  - refill/refill_arbiter.sv
  - refill/axi_burst_reader.sv
  - logic/commit_trace_fifo.sv
  - logic/uncore_top.sv
  - target: test
    files:
      - testbench/tb_uncore.sv
